//--- source/rdma_flow_pkg.sv
`default_nettype none

package rdma_flow_pkg;

    localparam int vfid_bits = 1;
    localparam int pid_bits = 3;
    localparam int flow_bits = vfid_bits + pid_bits; // vfid above pid.
    localparam int qpn_bits = 10;
    localparam int ssn_bits = 24;
    localparam int offs_bits = 4; // bounds N_OST to 16.

    // any opcode but the read request goes to the write side.
    localparam logic [7:0] opc_read_req = 8'h0c;
    localparam logic [7:0] opc_write_only = 8'h0a;

    // request as it arrives from the queue pair and leaves toward the wire.
    typedef struct packed {
        logic [7:0]           opcode;
        logic [qpn_bits-1:0]  qpn; // pid low with vfid above.
        logic [ssn_bits-1:0]  ssn;
        logic                 last;
        logic                 cmplt;
        logic [offs_bits-1:0] offs; // ring slot filled in on the way out.
    } rdma_req_t;

    // acknowledgement in, completion out.
    typedef struct packed {
        logic                 rd;
        logic [vfid_bits-1:0] vfid;
        logic [pid_bits-1:0]  pid;
        logic [ssn_bits-1:0]  ssn; // don't care on the ack side.
        logic                 cmplt; // don't care on the ack side.
    } rdma_ack_t;

    // contents of one ring slot.
    typedef struct packed {
        logic [ssn_bits-1:0] ssn;
        logic                last;
        logic                cmplt;
    } slot_t;

endpackage

`default_nettype wire

//--- source/ost_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module ost_tracker import rdma_flow_pkg::*; #(
    parameter int N_OST = 16
) (
    input  logic                 aclk,
    input  logic                 aresetn,

    input  logic [flow_bits-1:0] lk_flow,
    output logic                 lk_space,
    output logic [offs_bits-1:0] lk_offs,

    input  logic                 push,
    input  slot_t                push_slot,

    input  logic                 ret,
    input  logic [flow_bits-1:0] ret_flow,
    output logic                 ret_valid,
    output rdma_ack_t            ret_data,
    output logic                 ret_last
);

    localparam int idx_bits = $clog2(N_OST);
    localparam int n_flows = 2 ** flow_bits;
    localparam int n_slots = n_flows * N_OST;

    logic [n_flows-1:0][idx_bits-1:0] head_q;
    logic [n_flows-1:0][idx_bits-1:0] head_n;
    logic [n_flows-1:0][idx_bits-1:0] tail_q;
    logic [n_flows-1:0][idx_bits-1:0] tail_n;
    logic [n_flows-1:0]               issued_q;
    logic [n_flows-1:0]               issued_n;

    slot_t slot_mem [n_slots];

    logic [flow_bits+idx_bits-1:0] wr_addr;
    logic [flow_bits+idx_bits-1:0] rd_addr;

    logic                 ret_valid_q;
    logic [flow_bits-1:0] ret_flow_q;
    slot_t                rd_slot_q;

    // full when something is issued and head caught up with tail.
    assign lk_space = !(issued_q[lk_flow] && (head_q[lk_flow] == tail_q[lk_flow]));
    assign lk_offs = offs_bits'(head_q[lk_flow]);

    assign wr_addr = {lk_flow, head_q[lk_flow]};
    assign rd_addr = {ret_flow, tail_q[ret_flow]};

    always_comb begin
        head_n = head_q;
        tail_n = tail_q;
        issued_n = issued_q;

        if (ret) begin
            tail_n[ret_flow] = tail_q[ret_flow] + 1'b1;
            if (tail_n[ret_flow] == head_q[ret_flow]) begin
                issued_n[ret_flow] = 1'b0; // ring drained.
            end
        end

        // push last so a same-flow push keeps the ring marked busy.
        if (push) begin
            head_n[lk_flow] = head_q[lk_flow] + 1'b1;
            issued_n[lk_flow] = 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            head_q <= '0;
            tail_q <= '0;
            issued_q <= '0;
            ret_valid_q <= 1'b0;
        end else begin
            head_q <= head_n;
            tail_q <= tail_n;
            issued_q <= issued_n;
            ret_valid_q <= ret;
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            slot_mem[wr_addr] <= push_slot;
        end
        if (ret) begin
            rd_slot_q <= slot_mem[rd_addr]; // oldest entry of the flow.
            ret_flow_q <= ret_flow;
        end
    end

    always_comb begin
        ret_data = '0; // rd is restored by the combiner.
        ret_data.vfid = ret_flow_q[pid_bits +: vfid_bits];
        ret_data.pid = ret_flow_q[0 +: pid_bits];
        ret_data.ssn = rd_slot_q.ssn;
        ret_data.cmplt = rd_slot_q.cmplt;
    end

    assign ret_valid = ret_valid_q;
    assign ret_last = rd_slot_q.last;

endmodule

`default_nettype wire

//--- source/flow_combine.sv
`timescale 1ns/1ns
`default_nettype none

module flow_combine import rdma_flow_pkg::*; (
    input  logic                 aclk,
    input  logic                 aresetn,

    input  logic                 s_req_valid,
    output logic                 s_req_ready,
    input  rdma_req_t            s_req,
    output logic                 m_req_valid,
    input  logic                 m_req_ready,
    output rdma_req_t            m_req,

    input  logic                 s_ack_valid,
    output logic                 s_ack_ready,
    input  rdma_ack_t            s_ack,

    output logic                 q_valid,
    output rdma_ack_t            q_data,
    input  logic [offs_bits:0]   q_free,

    output logic [flow_bits-1:0] rd_lk_flow,
    input  logic                 rd_lk_space,
    input  logic [offs_bits-1:0] rd_lk_offs,
    output logic                 rd_push,
    output slot_t                rd_push_slot,
    output logic                 rd_ret,
    output logic [flow_bits-1:0] rd_ret_flow,
    input  logic                 rd_ret_valid,
    input  rdma_ack_t            rd_ret_data,
    input  logic                 rd_ret_last,

    output logic [flow_bits-1:0] wr_lk_flow,
    input  logic                 wr_lk_space,
    input  logic [offs_bits-1:0] wr_lk_offs,
    output logic                 wr_push,
    output slot_t                wr_push_slot,
    output logic                 wr_ret,
    output logic [flow_bits-1:0] wr_ret_flow,
    input  logic                 wr_ret_valid,
    input  rdma_ack_t            wr_ret_data,
    input  logic                 wr_ret_last
);

    logic                 en_q;
    logic                 ret_rd_q;
    logic                 req_rd;
    logic [flow_bits-1:0] req_flow;
    logic                 req_space;
    logic                 req_take;
    logic                 ack_take;
    logic                 ret_valid;
    logic                 ret_last;

    assign req_rd = (s_req.opcode == opc_read_req);
    assign req_flow = {s_req.qpn[pid_bits +: vfid_bits], s_req.qpn[0 +: pid_bits]};
    assign req_space = req_rd ? rd_lk_space : wr_lk_space;

    // two free slots cover the retire still in flight.
    assign s_ack_ready = (q_free >= (offs_bits + 1)'(2));
    assign ack_take = s_ack_valid && s_ack_ready;

    assign s_req_ready = en_q && req_space && m_req_ready && !ack_take; // ack wins.
    assign req_take = s_req_valid && s_req_ready;

    assign m_req_valid = req_take;
    always_comb begin
        m_req = s_req;
        m_req.offs = req_rd ? rd_lk_offs : wr_lk_offs;
    end

    assign rd_lk_flow = req_flow;
    assign wr_lk_flow = req_flow;
    assign rd_push = req_take && req_rd;
    assign wr_push = req_take && !req_rd;
    assign rd_push_slot = '{ssn: s_req.ssn, last: s_req.last, cmplt: s_req.cmplt};
    assign wr_push_slot = rd_push_slot;

    assign rd_ret = ack_take && s_ack.rd;
    assign wr_ret = ack_take && !s_ack.rd;
    assign rd_ret_flow = {s_ack.vfid, s_ack.pid};
    assign wr_ret_flow = rd_ret_flow;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            en_q <= 1'b0;
            ret_rd_q <= 1'b0;
        end else begin
            en_q <= 1'b1;
            if (ack_take) begin
                ret_rd_q <= s_ack.rd;
            end
        end
    end

    // only the slot marked last produces a completion.
    assign ret_valid = ret_rd_q ? rd_ret_valid : wr_ret_valid;
    assign ret_last = ret_rd_q ? rd_ret_last : wr_ret_last;
    assign q_valid = ret_valid && ret_last;

    always_comb begin
        q_data = ret_rd_q ? rd_ret_data : wr_ret_data;
        q_data.rd = ret_rd_q;
    end

endmodule

`default_nettype wire

//--- source/ack_queue.sv
`timescale 1ns/1ns
`default_nettype none

module ack_queue import rdma_flow_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic               aclk,
    input  logic               aresetn,

    input  logic               in_valid,
    input  rdma_ack_t          in_data,
    output logic [offs_bits:0] free,

    output logic               out_valid,
    input  logic               out_ready,
    output rdma_ack_t          out_data
);

    localparam int ptr_bits = $clog2(DEPTH);
    localparam logic [offs_bits:0] depth_cnt = (offs_bits + 1)'(DEPTH);

    rdma_ack_t mem [DEPTH];

    logic [ptr_bits-1:0] wr_ptr_q;
    logic [ptr_bits-1:0] rd_ptr_q;
    logic [offs_bits:0]  mem_cnt_q;
    logic [offs_bits:0]  mem_cnt_n;
    logic [offs_bits:0]  free_q;
    logic                out_valid_q;
    logic                out_valid_n;
    rdma_ack_t           out_data_q;

    logic pop;
    logic load_out;
    logic mem_rd;
    logic mem_wr;
    logic bypass;

    always_comb begin
        pop = out_valid_q && out_ready;
        load_out = !out_valid_q || pop;
        mem_rd = load_out && (mem_cnt_q != '0);
        bypass = load_out && (mem_cnt_q == '0) && in_valid; // straight to the output reg.
        mem_wr = in_valid && !bypass;

        mem_cnt_n = mem_cnt_q;
        if (mem_wr) begin
            mem_cnt_n = mem_cnt_n + 1'b1;
        end
        if (mem_rd) begin
            mem_cnt_n = mem_cnt_n - 1'b1;
        end

        out_valid_n = load_out ? (mem_rd || bypass) : out_valid_q;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            mem_cnt_q <= '0;
            out_valid_q <= 1'b0;
            free_q <= '0; // no credit until out of reset.
        end else begin
            if (mem_wr) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (mem_rd) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            mem_cnt_q <= mem_cnt_n;
            out_valid_q <= out_valid_n;
            free_q <= depth_cnt - mem_cnt_n - (offs_bits + 1)'(out_valid_n);
        end
    end

    always_ff @(posedge aclk) begin
        if (mem_wr) begin
            mem[wr_ptr_q] <= in_data;
        end
        if (mem_rd) begin
            out_data_q <= mem[rd_ptr_q];
        end else if (bypass) begin
            out_data_q <= in_data;
        end
    end

    assign free = free_q;
    assign out_valid = out_valid_q;
    assign out_data = out_data_q;

endmodule

`default_nettype wire

//--- source/rdma_flow_top.sv
`timescale 1ns/1ns
`default_nettype none

module rdma_flow_top import rdma_flow_pkg::*; #(
    parameter int N_OST = 16
) (
    input  logic      aclk,
    input  logic      aresetn,

    input  logic      s_req_valid,
    output logic      s_req_ready,
    input  rdma_req_t s_req,
    output logic      m_req_valid,
    input  logic      m_req_ready,
    output rdma_req_t m_req,

    input  logic      s_ack_valid,
    output logic      s_ack_ready,
    input  rdma_ack_t s_ack,
    output logic      m_cpl_valid,
    input  logic      m_cpl_ready,
    output rdma_ack_t m_cpl
);

    logic               q_valid;
    rdma_ack_t          q_data;
    logic [offs_bits:0] q_free;

    logic [flow_bits-1:0] rd_lk_flow;
    logic                 rd_lk_space;
    logic [offs_bits-1:0] rd_lk_offs;
    logic                 rd_push;
    slot_t                rd_push_slot;
    logic                 rd_ret;
    logic [flow_bits-1:0] rd_ret_flow;
    logic                 rd_ret_valid;
    rdma_ack_t            rd_ret_data;
    logic                 rd_ret_last;

    logic [flow_bits-1:0] wr_lk_flow;
    logic                 wr_lk_space;
    logic [offs_bits-1:0] wr_lk_offs;
    logic                 wr_push;
    slot_t                wr_push_slot;
    logic                 wr_ret;
    logic [flow_bits-1:0] wr_ret_flow;
    logic                 wr_ret_valid;
    rdma_ack_t            wr_ret_data;
    logic                 wr_ret_last;

    ost_tracker #(
        .N_OST(N_OST)
    ) i_rd_tracker (
        .aclk(aclk),
        .aresetn(aresetn),
        .lk_flow(rd_lk_flow),
        .lk_space(rd_lk_space),
        .lk_offs(rd_lk_offs),
        .push(rd_push),
        .push_slot(rd_push_slot),
        .ret(rd_ret),
        .ret_flow(rd_ret_flow),
        .ret_valid(rd_ret_valid),
        .ret_data(rd_ret_data),
        .ret_last(rd_ret_last)
    );

    ost_tracker #(
        .N_OST(N_OST)
    ) i_wr_tracker (
        .aclk(aclk),
        .aresetn(aresetn),
        .lk_flow(wr_lk_flow),
        .lk_space(wr_lk_space),
        .lk_offs(wr_lk_offs),
        .push(wr_push),
        .push_slot(wr_push_slot),
        .ret(wr_ret),
        .ret_flow(wr_ret_flow),
        .ret_valid(wr_ret_valid),
        .ret_data(wr_ret_data),
        .ret_last(wr_ret_last)
    );

    flow_combine i_combine (
        .aclk(aclk),
        .aresetn(aresetn),
        .s_req_valid(s_req_valid),
        .s_req_ready(s_req_ready),
        .s_req(s_req),
        .m_req_valid(m_req_valid),
        .m_req_ready(m_req_ready),
        .m_req(m_req),
        .s_ack_valid(s_ack_valid),
        .s_ack_ready(s_ack_ready),
        .s_ack(s_ack),
        .q_valid(q_valid),
        .q_data(q_data),
        .q_free(q_free),
        .rd_lk_flow(rd_lk_flow),
        .rd_lk_space(rd_lk_space),
        .rd_lk_offs(rd_lk_offs),
        .rd_push(rd_push),
        .rd_push_slot(rd_push_slot),
        .rd_ret(rd_ret),
        .rd_ret_flow(rd_ret_flow),
        .rd_ret_valid(rd_ret_valid),
        .rd_ret_data(rd_ret_data),
        .rd_ret_last(rd_ret_last),
        .wr_lk_flow(wr_lk_flow),
        .wr_lk_space(wr_lk_space),
        .wr_lk_offs(wr_lk_offs),
        .wr_push(wr_push),
        .wr_push_slot(wr_push_slot),
        .wr_ret(wr_ret),
        .wr_ret_flow(wr_ret_flow),
        .wr_ret_valid(wr_ret_valid),
        .wr_ret_data(wr_ret_data),
        .wr_ret_last(wr_ret_last)
    );

    ack_queue #(
        .DEPTH(N_OST)
    ) i_cpl_queue (
        .aclk(aclk),
        .aresetn(aresetn),
        .in_valid(q_valid),
        .in_data(q_data),
        .free(q_free),
        .out_valid(m_cpl_valid),
        .out_ready(m_cpl_ready),
        .out_data(m_cpl)
    );

endmodule

`default_nettype wire

//--- tests/rdma_flow_checker.sv
`timescale 1ns/1ns
`default_nettype none

module rdma_flow_checker import rdma_flow_pkg::*; (
    input logic      aclk,
    input logic      aresetn,
    input logic      s_req_valid,
    input logic      s_req_ready,
    input logic      m_req_valid,
    input logic      m_req_ready,
    input rdma_req_t m_req,
    input logic      s_ack_ready,
    input logic      m_cpl_valid,
    input logic      m_cpl_ready,
    input rdma_ack_t m_cpl
);

    int fail_count = 0;

    req_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        (m_req_valid && !m_req_ready) |=> (m_req_valid && $stable(m_req)))
        else begin
            $error("m_req dropped or changed before its transfer");
            fail_count++;
        end

    cpl_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        (m_cpl_valid && !m_cpl_ready) |=> (m_cpl_valid && $stable(m_cpl)))
        else begin
            $error("m_cpl dropped or changed before its transfer");
            fail_count++;
        end

    // nothing leaves the zero latency path without a request at the input.
    req_source: assert property (@(posedge aclk) disable iff (!aresetn)
        m_req_valid |-> s_req_valid)
        else begin
            $error("m_req_valid without s_req_valid");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge aclk)
        (!aresetn && $past(!aresetn))
            |-> !(s_req_ready || m_req_valid || s_ack_ready || m_cpl_valid))
        else begin
            $error("handshake output high during reset");
            fail_count++;
        end

endmodule

bind rdma_flow_top rdma_flow_checker i_checker (
    .aclk(aclk),
    .aresetn(aresetn),
    .s_req_valid(s_req_valid),
    .s_req_ready(s_req_ready),
    .m_req_valid(m_req_valid),
    .m_req_ready(m_req_ready),
    .m_req(m_req),
    .s_ack_ready(s_ack_ready),
    .m_cpl_valid(m_cpl_valid),
    .m_cpl_ready(m_cpl_ready),
    .m_cpl(m_cpl)
);

`default_nettype wire

//--- tests/rdma_flow_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rdma_flow_tb import rdma_flow_pkg::*; ();

    localparam int N_OST = 4;
    localparam int n_model = 2 ** (flow_bits + 1); // direction on top of vfid and pid.
    localparam int half_period = 50;

    logic      aclk;
    logic      aresetn;
    logic      s_req_valid;
    logic      s_req_ready;
    rdma_req_t s_req;
    logic      m_req_valid;
    logic      m_req_ready;
    rdma_req_t m_req;
    logic      s_ack_valid;
    logic      s_ack_ready;
    rdma_ack_t s_ack;
    logic      m_cpl_valid;
    logic      m_cpl_ready;
    rdma_ack_t m_cpl;

    // reference model of every ring.
    slot_t     ring [n_model][N_OST];
    int        head_cnt [n_model];
    int        ost_cnt [n_model];
    rdma_ack_t exp_cpl [$];
    logic      cpl_in_flight; // retired last slot not yet in the queue.

    logic req_pend;
    logic ack_pend;
    int   errors;
    int   n_req;
    int   n_ack;
    int   n_cpl;
    int   ack_stalls;

    rdma_flow_top #(
        .N_OST(N_OST)
    ) i_dut (
        .aclk(aclk),
        .aresetn(aresetn),
        .s_req_valid(s_req_valid),
        .s_req_ready(s_req_ready),
        .s_req(s_req),
        .m_req_valid(m_req_valid),
        .m_req_ready(m_req_ready),
        .m_req(m_req),
        .s_ack_valid(s_ack_valid),
        .s_ack_ready(s_ack_ready),
        .s_ack(s_ack),
        .m_cpl_valid(m_cpl_valid),
        .m_cpl_ready(m_cpl_ready),
        .m_cpl(m_cpl)
    );

    initial begin
        aclk = 1'b0;
        forever #half_period aclk = ~aclk;
    end

    function automatic int req_flow(rdma_req_t r);
        logic rd;
        rd = (r.opcode == opc_read_req);
        return int'({rd, r.qpn[pid_bits +: vfid_bits], r.qpn[pid_bits-1:0]});
    endfunction

    function automatic int ack_flow(rdma_ack_t a);
        return int'({a.rd, a.vfid, a.pid});
    endfunction

    function automatic int total_ost();
        int f;
        int sum;
        sum = 0;
        for (f = 0; f < n_model; f++) begin
            sum += ost_cnt[f];
        end
        return sum;
    endfunction

    task automatic clear_model();
        int f;
        for (f = 0; f < n_model; f++) begin
            head_cnt[f] = 0;
            ost_cnt[f] = 0;
        end
        exp_cpl.delete();
        cpl_in_flight = 1'b0;
    endtask

    task automatic new_req(input logic force_last);
        int pick;
        pick = $urandom_range(2);
        s_req.opcode = (pick == 0) ? opc_read_req : (pick == 1) ? opc_write_only : 8'($urandom);
        s_req.qpn = qpn_bits'($urandom);
        s_req.ssn = ssn_bits'($urandom);
        s_req.last = force_last | 1'($urandom);
        s_req.cmplt = 1'($urandom);
        s_req.offs = offs_bits'($urandom); // overwritten by the DUT.
        req_pend = 1'b1;
    endtask

    task automatic apply_reset();
        int k;
        @(negedge aclk);
        aresetn = 1'b0;
        s_req_valid = 1'b0;
        s_ack_valid = 1'b0;
        req_pend = 1'b0;
        ack_pend = 1'b0;
        for (k = 0; k < 2; k++) begin
            @(negedge aclk);
            if ({s_req_ready, m_req_valid, s_ack_ready, m_cpl_valid} !== 4'h0) begin
                errors++;
                $write("ERROR reset outputs: s_req_ready=%h m_req_valid=%h ",
                       s_req_ready, m_req_valid);
                $display("s_ack_ready=%h m_cpl_valid=%h expected 0",
                         s_ack_ready, m_cpl_valid);
            end
        end
        aresetn = 1'b1;
        clear_model();
    endtask

    // drive at the falling edge, sample mid-low phase, update model.
    task automatic step(input int req_pct, input int ack_pct, input logic force_last,
                        input int mreq_pct, input int cpl_pct, input int sel_flow);
        int        f;
        int        k;
        int        start;
        int        idx;
        logic      ack_taken;
        logic      req_taken;
        logic      exp_ready;
        logic      exp_ack_ready;
        rdma_req_t exp_req;
        rdma_ack_t cpl;
        slot_t     ent;
        @(negedge aclk);
        if (!req_pend) begin
            if (sel_flow >= 0) begin
                new_req(1'b0);
                s_req.opcode = sel_flow[flow_bits] ? opc_read_req : opc_write_only;
                s_req.qpn[flow_bits-1:0] = sel_flow[flow_bits-1:0];
            end else if ($urandom_range(99) < req_pct) begin
                new_req(force_last);
            end
        end
        if (!ack_pend && ($urandom_range(99) < ack_pct)) begin
            start = $urandom_range(n_model - 1);
            for (k = 0; k < n_model && !ack_pend; k++) begin
                f = (start + k) % n_model;
                if (ost_cnt[f] > 0) begin
                    s_ack.rd = f[flow_bits];
                    s_ack.vfid = f[pid_bits +: vfid_bits];
                    s_ack.pid = f[pid_bits-1:0];
                    s_ack.ssn = ssn_bits'($urandom);
                    s_ack.cmplt = 1'($urandom);
                    ack_pend = 1'b1;
                end
            end
        end
        s_req_valid = req_pend;
        s_ack_valid = ack_pend;
        m_req_ready = ($urandom_range(99) < mreq_pct);
        m_cpl_ready = ($urandom_range(99) < cpl_pct);
        #20;
        // queue holds what is expected minus the retire still on its way.
        exp_ack_ready = ((N_OST - (exp_cpl.size() - int'(cpl_in_flight))) >= 2);
        if (s_ack_ready !== exp_ack_ready) begin
            errors++;
            $display("ERROR s_ack_ready: got %h expected %h", s_ack_ready, exp_ack_ready);
        end
        if (m_cpl_valid && m_cpl_ready) begin
            if (exp_cpl.size() == 0) begin
                errors++;
                $display("completion arrived while none was expected");
            end else begin
                if (m_cpl !== exp_cpl[0]) begin
                    errors++;
                    $display("ERROR m_cpl: got %h expected %h", m_cpl, exp_cpl[0]);
                end
                void'(exp_cpl.pop_front());
                n_cpl++;
            end
        end
        ack_taken = s_ack_valid && s_ack_ready;
        f = req_flow(s_req);
        exp_ready = (ost_cnt[f] < N_OST) && m_req_ready && !ack_taken; // ack first.
        if (s_req_ready !== exp_ready) begin
            errors++;
            $display("ERROR s_req_ready: got %h expected %h", s_req_ready, exp_ready);
        end
        req_taken = s_req_valid && s_req_ready;
        if (m_req_valid !== req_taken) begin
            errors++;
            $display("ERROR m_req_valid: got %h expected %h", m_req_valid, req_taken);
        end
        if (req_taken) begin
            exp_req = s_req;
            exp_req.offs = offs_bits'(head_cnt[f]);
            if (m_req !== exp_req) begin
                errors++;
                $display("ERROR m_req: got %h expected %h", m_req, exp_req);
            end
            ring[f][head_cnt[f]] = '{ssn: s_req.ssn, last: s_req.last, cmplt: s_req.cmplt};
            head_cnt[f] = (head_cnt[f] + 1) % N_OST;
            ost_cnt[f]++;
            req_pend = 1'b0;
            n_req++;
        end
        cpl_in_flight = 1'b0;
        if (ack_taken) begin
            f = ack_flow(s_ack);
            idx = (head_cnt[f] - ost_cnt[f] + N_OST) % N_OST; // oldest entry.
            ent = ring[f][idx];
            ost_cnt[f]--;
            if (ent.last) begin
                cpl.rd = s_ack.rd;
                cpl.vfid = s_ack.vfid;
                cpl.pid = s_ack.pid;
                cpl.ssn = ent.ssn;
                cpl.cmplt = ent.cmplt;
                exp_cpl.push_back(cpl);
                cpl_in_flight = 1'b1;
                if (exp_cpl.size() > N_OST) begin
                    errors++;
                    $display("completion queue took more entries than it can hold");
                end
            end
            ack_pend = 1'b0;
            n_ack++;
        end
        if (!s_ack_ready) begin
            ack_stalls++;
        end
    endtask

    task automatic drain(input int limit);
        int guard;
        guard = 0;
        while (guard < limit && (req_pend || ack_pend || exp_cpl.size() != 0
                                 || total_ost() != 0)) begin
            step(0, 100, 1'b0, 100, 100, -1);
            guard++;
        end
        if (req_pend || ack_pend || exp_cpl.size() != 0 || total_ost() != 0) begin
            errors++;
            $display("timeout: %0d completions still missing after %0d cycles",
                     exp_cpl.size(), limit);
        end
    endtask

    task automatic refill_all();
        int f;
        int k;
        int guard;
        for (f = 0; f < n_model; f++) begin
            for (k = 0; k < N_OST; k++) begin
                guard = 0;
                step(0, 0, 1'b0, 100, 100, f);
                while (req_pend && guard < 20) begin
                    step(0, 0, 1'b0, 100, 100, f);
                    guard++;
                end
                if (req_pend) begin
                    errors++;
                    $display("timeout: flow %0d refused request %0d after reset", f, k);
                end
            end
        end
    endtask

    initial begin
        int k;
        void'($urandom(15));
        aresetn = 1'b0;
        s_req_valid = 1'b0;
        s_req = '0;
        m_req_ready = 1'b0;
        s_ack_valid = 1'b0;
        s_ack = '0;
        m_cpl_ready = 1'b0;
        req_pend = 1'b0;
        ack_pend = 1'b0;
        cpl_in_flight = 1'b0;
        errors = 0;
        n_req = 0;
        n_ack = 0;
        n_cpl = 0;
        ack_stalls = 0;

        apply_reset();
        for (k = 0; k < 1500; k++) begin
            step(70, 30, 1'b0, 70, 60, -1);
        end

        // completions held back while every new request is marked last.
        ack_stalls = 0;
        for (k = 0; k < 300; k++) begin
            step(50, 70, 1'b1, 80, 0, -1);
        end
        if (ack_stalls == 0) begin
            errors++;
            $display("s_ack_ready never fell while completions were held back");
        end
        drain(3000);

        // rings and completion queue stay busy into the reset.
        for (k = 0; k < 200; k++) begin
            step(70, 30, 1'b1, 70, 0, -1);
        end
        apply_reset();
        refill_all();
        for (k = 0; k < 8; k++) begin
            step(0, 0, 1'b0, 100, 100, 0); // flow 0 is full here.
        end
        drain(3000);

        errors += i_dut.i_checker.fail_count;
        $display("errors: %0d requests: %0d acks: %0d completions: %0d",
                 errors, n_req, n_ack, n_cpl);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
source/rdma_flow_pkg.sv
source/ost_tracker.sv
source/flow_combine.sv
source/ack_queue.sv
source/rdma_flow_top.sv
tests/rdma_flow_checker.sv
tests/rdma_flow_tb.sv

//--- Makefile
VERILATOR  := verilator
TOP        := rdma_flow_tb
FILELIST   := all.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := All checks passed
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert --top-module $(TOP) --Mdir $(OBJ_DIR)

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
